// ==== source/mod_arith_pkg.sv ====
/*
  Shared constants and types for the modular add/subtract engine.
  Holds the prime modulus, datapath widths, pipeline depth, result queue
  depth, the APB register map and the command opcode encoding.
*/
`default_nettype none

package mod_arith_pkg;

  // Largest prime that fits in one 32-bit word (2^32 - 5)
  localparam logic [31:0] MOD_P = 32'd4294967291;

  localparam int DAT_BITS = 32;
  localparam int TAG_BITS = 8;

  // Each pipeline stage resolves one slice of the word
  localparam int LEVEL = 4;
  localparam int SLICE_BITS = DAT_BITS / LEVEL;

  // Result queue entries, a power of two so the pointers wrap by themselves
  localparam int FIFO_DEPTH = 4;

  // APB register map, byte addresses
  localparam logic [7:0] ADDR_OPA    = 8'h00;
  localparam logic [7:0] ADDR_OPB    = 8'h04;
  localparam logic [7:0] ADDR_CMD    = 8'h08;
  localparam logic [7:0] ADDR_STATUS = 8'h0C;
  localparam logic [7:0] ADDR_RESULT = 8'h10;
  localparam logic [7:0] ADDR_RTAG   = 8'h14;

  // Bit 0 of the command word
  typedef enum logic [0:0] {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } mod_op_e;

  typedef logic [DAT_BITS-1:0] dat_t;
  typedef logic [TAG_BITS-1:0] tag_t;

endpackage

`default_nettype wire

// ==== source/mod_arith_ifs.sv ====
/*
  Valid/ready interfaces of the engine.
  mod_op_if carries a command into the pipeline and mod_res_if carries a
  result and its tag, both from the pipeline and out of the result queue.
*/
`timescale 1ns/10ps
`default_nettype none

interface mod_op_if;
  import mod_arith_pkg::*;

  logic    val;
  logic    rdy;
  mod_op_e op;
  tag_t    tag;
  dat_t    a;
  dat_t    b;

  // The issuing side holds val and payload until rdy is seen
  modport src (output val, op, tag, a, b, input rdy);
  modport dst (input val, op, tag, a, b, output rdy);
endinterface

interface mod_res_if;
  import mod_arith_pkg::*;

  logic val;
  logic rdy;
  dat_t dat;
  tag_t tag;

  // On the queue output val means not empty and rdy means pop
  modport src (output val, dat, tag, input rdy);
  modport dst (input val, dat, tag, output rdy);
endinterface

`default_nettype wire

// ==== source/apb_cmd_regs.sv ====
/*
  APB slave of the engine.
  Keeps the two operand registers, turns a command write into a transfer
  on the command interface with wait states, and serves status, tag and
  result reads from the head of the result queue.
*/
`timescale 1ns/10ps
`default_nettype none

module apb_cmd_regs (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  logic [7:0]          i_paddr,
  input  mod_arith_pkg::dat_t i_pwdata,
  output mod_arith_pkg::dat_t o_prdata,
  output logic                o_pready,
  output logic                o_pslverr,
  input  logic [3:0]          i_level,
  mod_op_if.src               o_cmd,
  mod_res_if.dst              i_res
);
  import mod_arith_pkg::*;

  dat_t opa;
  dat_t opb;
  logic acc;
  logic cmd_wr;
  logic pop;
  logic slverr_d;
  dat_t prdata_d;

  // Access phase of an APB transfer
  assign acc = i_psel & i_penable;
  assign cmd_wr = acc & i_pwrite & (i_paddr == ADDR_CMD);

  // The command is offered for the whole access phase; APB keeps the
  // write data stable there, and the operands cannot change meanwhile
  assign o_cmd.val = cmd_wr;
  assign o_cmd.op  = mod_op_e'(i_pwdata[0]);
  assign o_cmd.tag = i_pwdata[15:8];
  assign o_cmd.a   = opa;
  assign o_cmd.b   = opb;

  // Command writes wait for the pipeline, everything else is zero-wait
  assign o_pready = acc & (~cmd_wr | o_cmd.rdy);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      opa <= '0;
      opb <= '0;
    end else if (acc && i_pwrite) begin
      if (i_paddr == ADDR_OPA) begin
        opa <= i_pwdata;
      end
      if (i_paddr == ADDR_OPB) begin
        opb <= i_pwdata;
      end
    end
  end

  // Address decode for read data, errors and queue pops
  always_comb begin
    prdata_d = '0;
    slverr_d = 1'b0;
    pop      = 1'b0;
    case (i_paddr)
      ADDR_OPA:    prdata_d = opa;
      ADDR_OPB:    prdata_d = opb;
      ADDR_CMD: begin
        // Write-only, reads back as zero
        prdata_d = '0;
      end
      ADDR_STATUS: prdata_d = DAT_BITS'({i_level, 3'b000, i_res.val});
      ADDR_RESULT: begin
        if (!i_pwrite) begin
          if (i_res.val) begin
            prdata_d = i_res.dat;
            pop = 1'b1;
          end else begin
            slverr_d = 1'b1;
          end
        end
      end
      ADDR_RTAG: begin
        // Peeks at the head tag, the queue is left untouched
        if (i_res.val) begin
          prdata_d = DAT_BITS'(i_res.tag);
        end
      end
      default:     slverr_d = 1'b1;
    endcase
  end

  // A read access lasts one cycle, so the pop happens exactly once
  assign i_res.rdy = acc & ~i_pwrite & pop;
  assign o_prdata  = (acc && !i_pwrite) ? prdata_d : '0;
  assign o_pslverr = o_pready & slverr_d;

  // Once offered, the command must not change until the pipeline takes it
  a_cmd_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    o_cmd.val && !o_cmd.rdy |=>
      o_cmd.val && $stable({o_cmd.op, o_cmd.tag, o_cmd.a, o_cmd.b}));

endmodule

`default_nettype wire

// ==== source/mod_addsub_pipe.sv ====
/*
  Pipelined modular add/subtract over the fixed prime MOD_P.
  Each stage resolves one slice of two candidate chains, the plain result
  and the one corrected by P; the last stage keeps the one in [0, P-1].
  A command takes LEVEL cycles without back-pressure.
*/
`timescale 1ns/10ps
`default_nettype none

module mod_addsub_pipe (
  input  logic    i_clk,
  input  logic    i_rst,
  mod_op_if.dst   i_cmd,
  mod_res_if.src  o_res
);
  import mod_arith_pkg::*;

  // Per-stage view, index 0 is the command input, index g+1 is stage g
  logic [LEVEL:0] val_s;
  logic [LEVEL:0] rdy;
  logic [LEVEL:0] c0_s;
  logic [LEVEL:0] c1_s;
  mod_op_e        op_s  [0:LEVEL];
  tag_t           tag_s [0:LEVEL];
  dat_t           r0_s  [0:LEVEL];
  dat_t           r1_s  [0:LEVEL];
  dat_t           a_s   [0:LEVEL-1];
  dat_t           b_s   [0:LEVEL-1];
  logic           use_alt;

  assign val_s[0] = i_cmd.val;
  assign op_s[0]  = i_cmd.op;
  assign tag_s[0] = i_cmd.tag;
  assign a_s[0]   = i_cmd.a;
  assign b_s[0]   = i_cmd.b;
  assign c0_s[0]  = 1'b0;
  assign c1_s[0]  = 1'b0;
  assign r0_s[0]  = '0;
  assign r1_s[0]  = '0;

  // A stage may load when its successor is empty or moving on
  always_comb begin
    rdy[LEVEL] = o_res.rdy;
    for (int i = LEVEL - 1; i >= 0; i--) begin
      rdy[i] = ~val_s[i+1] | rdy[i+1];
    end
  end

  assign i_cmd.rdy = rdy[0];

  for (genvar g = 0; g < LEVEL; g++) begin : g_stage
    logic [SLICE_BITS:0] sa, sb, sp, first, second;
    dat_t    nxt0, nxt1;
    logic    v_q, c0_q, c1_q;
    mod_op_e op_q;
    tag_t    tag_q;
    dat_t    r0_q, r1_q;

    assign sa = {1'b0, a_s[g][g*SLICE_BITS +: SLICE_BITS]};
    assign sb = {1'b0, b_s[g][g*SLICE_BITS +: SLICE_BITS]};
    assign sp = {1'b0, MOD_P[g*SLICE_BITS +: SLICE_BITS]};

    always_comb begin
      // Chain 0 is a+b or a-b; the top bit is the carry or the borrow
      // Chain 1 applies -P or +P on top of chain 0 for the same slice
      if (op_s[g] == OP_ADD) begin
        first  = sa + sb + c0_s[g];
        second = {1'b0, first[SLICE_BITS-1:0]} - sp - c1_s[g];
      end else begin
        first  = sa - sb - c0_s[g];
        second = {1'b0, first[SLICE_BITS-1:0]} + sp + c1_s[g];
      end
      nxt0 = r0_s[g];
      nxt0[g*SLICE_BITS +: SLICE_BITS] = first[SLICE_BITS-1:0];
      nxt1 = r1_s[g];
      nxt1[g*SLICE_BITS +: SLICE_BITS] = second[SLICE_BITS-1:0];
    end

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        v_q <= 1'b0;
      end else if (rdy[g]) begin
        v_q <= val_s[g];
      end
    end

    // The stage holds everything while its successor is stalled
    always_ff @(posedge i_clk) begin
      if (rdy[g]) begin
        op_q  <= op_s[g];
        tag_q <= tag_s[g];
        r0_q  <= nxt0;
        r1_q  <= nxt1;
        c0_q  <= first[SLICE_BITS];
        c1_q  <= second[SLICE_BITS];
      end
    end

    assign val_s[g+1] = v_q;
    assign op_s[g+1]  = op_q;
    assign tag_s[g+1] = tag_q;
    assign r0_s[g+1]  = r0_q;
    assign r1_s[g+1]  = r1_q;
    assign c0_s[g+1]  = c0_q;
    assign c1_s[g+1]  = c1_q;

    // Operands are only needed while slices remain
    if (g < LEVEL - 1) begin : g_ops
      dat_t a_q, b_q;

      always_ff @(posedge i_clk) begin
        if (rdy[g]) begin
          a_q <= a_s[g];
          b_q <= b_s[g];
        end
      end

      assign a_s[g+1] = a_q;
      assign b_s[g+1] = b_q;
    end
  end

  // ADD: a+b-P unless the 33-bit value a+b lies below P
  // SUB: a-b unless it borrowed, then a-b+P
  always_comb begin
    if (op_s[LEVEL] == OP_ADD) begin
      use_alt = ~(c1_s[LEVEL] & ~c0_s[LEVEL]);
    end else begin
      use_alt = c0_s[LEVEL];
    end
  end

  assign o_res.val = val_s[LEVEL];
  assign o_res.tag = tag_s[LEVEL];
  assign o_res.dat = use_alt ? r1_s[LEVEL] : r0_s[LEVEL];

  // The engine does not reduce its inputs
  a_opnd_range: assert property (@(posedge i_clk) disable iff (i_rst)
    i_cmd.val && i_cmd.rdy |-> (i_cmd.a < MOD_P) && (i_cmd.b < MOD_P));

  a_rst_quiet: assert property (@(posedge i_clk) i_rst |=> !o_res.val);

endmodule

`default_nettype wire

// ==== source/result_fifo.sv ====
/*
  In-order queue of results and tags between the pipeline and APB.
  A circular buffer with read and write pointers; the pipeline stalls
  when it is full, and an APB result read pops the head.
*/
`timescale 1ns/10ps
`default_nettype none

module result_fifo (
  input  logic       i_clk,
  input  logic       i_rst,
  mod_res_if.dst     i_push,
  mod_res_if.src     o_head,
  output logic [3:0] o_level
);
  import mod_arith_pkg::*;

  dat_t mem_dat [FIFO_DEPTH];
  tag_t mem_tag [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
  logic [3:0] count;
  logic full;
  logic push;
  logic pop;

  assign full = (count == 4'(FIFO_DEPTH));
  assign i_push.rdy = ~full;
  assign push = i_push.val & i_push.rdy;
  assign pop  = o_head.val & o_head.rdy;

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem_dat[wr_ptr] <= i_push.dat;
      mem_tag[wr_ptr] <= i_push.tag;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + 4'(push) - 4'(pop);
    end
  end

  assign o_head.val = (count != 4'd0);
  assign o_head.dat = mem_dat[rd_ptr];
  assign o_head.tag = mem_tag[rd_ptr];
  assign o_level = count;

  // The APB side must only pop when a result is present
  a_no_empty_pop: assert property (@(posedge i_clk) disable iff (i_rst)
    o_head.rdy |-> o_head.val);

  // A result refused while full stays offered until the queue takes it
  a_full_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_push.val && full |=> i_push.val && $stable({i_push.dat, i_push.tag}));

endmodule

`default_nettype wire

// ==== source/mod_arith_top.sv ====
/*
  Top level of the APB modular add/subtract engine.
  Connects the register block, the pipeline and the result queue and
  exposes plain APB slave ports.
*/
`timescale 1ns/10ps
`default_nettype none

module mod_arith_top (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  logic [7:0]          i_paddr,
  input  mod_arith_pkg::dat_t i_pwdata,
  output mod_arith_pkg::dat_t o_prdata,
  output logic                o_pready,
  output logic                o_pslverr
);

  // Command path, pipeline output and queue head
  mod_op_if  cmd_if ();
  mod_res_if pipe_res_if ();
  mod_res_if head_if ();

  logic [3:0] q_level;

  apb_cmd_regs apb_cmd_regs_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .i_level   (q_level),
    .o_cmd     (cmd_if.src),
    .i_res     (head_if.dst)
  );

  mod_addsub_pipe mod_addsub_pipe_i (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_cmd (cmd_if.dst),
    .o_res (pipe_res_if.src)
  );

  result_fifo result_fifo_i (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_push  (pipe_res_if.dst),
    .o_head  (head_if.src),
    .o_level (q_level)
  );

endmodule

`default_nettype wire

// ==== tb/tb_mod_arith_top.sv ====
/*
  Directed testbench for the APB modular add/subtract engine.
  Drives APB accesses into mod_arith_top, polls STATUS for results and
  compares them with a wide-arithmetic reference model.
  Covers register readback, ADD and SUB cases, a full result queue and error responses.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_mod_arith_top;
  import mod_arith_pkg::*;

  localparam int CLK_NS = 10;
  localparam logic [31:0] RAND_SEED = 32'h7660_f522;
  // About 150 accesses of three cycles each, plus polling, with a wide margin
  localparam int MAX_ACCESSES = 200;
  localparam int CYC_PER_ACCESS = 10;
  localparam int TIMEOUT_NS = MAX_ACCESSES * CYC_PER_ACCESS * CLK_NS;
  localparam int POLL_LIMIT = 50;

  logic i_clk;
  logic i_rst;
  logic i_psel;
  logic i_penable;
  logic i_pwrite;
  logic [7:0] i_paddr;
  dat_t i_pwdata;
  dat_t o_prdata;
  logic o_pready;
  logic o_pslverr;

  int dat_errs;
  int tag_errs;
  int bit_errs;
  int misc_errs;
  dat_t exp_q[$];
  tag_t tag_q[$];

  mod_arith_top dut_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr)
  );

  always #(CLK_NS / 2) i_clk = ~i_clk;

  // Setup phase, then access phase until the slave is ready; sampled on the falling edge
  task automatic apb_access(input logic wr, input logic [7:0] addr, input dat_t wdata,
                            output dat_t rdata, output logic err);
    int waits;
    @(posedge i_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= wr;
    i_paddr   <= addr;
    i_pwdata  <= wdata;
    @(posedge i_clk);
    i_penable <= 1'b1;
    @(negedge i_clk);
    waits = 0;
    while (!o_pready) begin
      waits++;
      @(negedge i_clk);
    end
    // Only command writes may be held off by the pipeline
    if (waits != 0 && !(wr && addr == ADDR_CMD)) begin
      misc_errs++;
      $display("Access to address 0x%02h took %0d wait states", addr, waits);
    end
    rdata = o_prdata;
    err   = o_pslverr;
    @(posedge i_clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input dat_t wdata, output logic err);
    dat_t unused;
    apb_access(1'b1, addr, wdata, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output dat_t rdata, output logic err);
    apb_access(1'b0, addr, '0, rdata, err);
  endtask

  // (a+b) mod P and (a-b) mod P, worked out two bits wider than the operands
  function automatic dat_t model_result(mod_op_e op, dat_t a, dat_t b);
    logic [33:0] wide;
    if (op == OP_ADD) wide = 34'(a) + 34'(b);
    else wide = 34'(a) + 34'(MOD_P) - 34'(b);
    if (wide >= 34'(MOD_P)) wide = wide - 34'(MOD_P);
    return wide[31:0];
  endfunction

  function automatic dat_t cmd_word(mod_op_e op, tag_t tag);
    return {16'h0000, tag, 7'h00, op};
  endfunction

  task automatic check_dat(input string name, input dat_t got, input dat_t exp);
    if (got !== exp) begin
      dat_errs++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
      tag_errs++;
      $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Operands first, then the command word; the model result goes into the queues
  task automatic issue_cmd(input mod_op_e op, input dat_t a, input dat_t b, input tag_t tag);
    logic err;
    apb_write(ADDR_OPA, a, err);
    apb_write(ADDR_OPB, b, err);
    apb_write(ADDR_CMD, cmd_word(op, tag), err);
    check_err("pslverr on command write", err, 1'b0);
    exp_q.push_back(model_result(op, a, b));
    tag_q.push_back(tag);
  endtask

  // Polls STATUS bit 0, then peeks the tag and pops the value
  task automatic collect_result();
    dat_t rd;
    logic err;
    int polls;
    polls = 0;
    rd = '0;
    while (!rd[0] && polls < POLL_LIMIT) begin
      apb_read(ADDR_STATUS, rd, err);
      polls++;
    end
    if (!rd[0]) begin
      misc_errs++;
      $display("No result showed up in STATUS after %0d polls", POLL_LIMIT);
    end
    apb_read(ADDR_RTAG, rd, err);
    check_tag("rtag", rd[TAG_BITS-1:0], tag_q.pop_front());
    apb_read(ADDR_RESULT, rd, err);
    check_dat("result", rd, exp_q.pop_front());
    check_err("pslverr on result read", err, 1'b0);
  endtask

  task automatic run_op(input mod_op_e op, input dat_t a, input dat_t b, input tag_t tag);
    issue_cmd(op, a, b, tag);
    collect_result();
  endtask

  task automatic reset_and_regs();
    dat_t rd;
    logic err;
    apb_read(ADDR_STATUS, rd, err);
    check_dat("status after reset", rd, '0);
    apb_write(ADDR_OPA, 32'h1234_5678, err);
    apb_write(ADDR_OPB, 32'h0BAD_F00D, err);
    apb_read(ADDR_OPA, rd, err);
    check_dat("opa readback", rd, 32'h1234_5678);
    apb_read(ADDR_OPB, rd, err);
    check_dat("opb readback", rd, 32'h0BAD_F00D);
  endtask

  task automatic add_cases();
    run_op(OP_ADD, 32'd0, 32'd0, 8'h01);
    run_op(OP_ADD, MOD_P - 1, 32'd1, 8'h02);
    run_op(OP_ADD, MOD_P - 1, MOD_P - 1, 8'h03);
    for (int i = 0; i < 4; i++) begin
      run_op(OP_ADD, $urandom % MOD_P, $urandom % MOD_P, tag_t'(8'h10 + i));
    end
  endtask

  task automatic sub_cases();
    run_op(OP_SUB, 32'd5, 32'd3, 8'h21);
    run_op(OP_SUB, 32'd3, 32'd5, 8'h22);
    run_op(OP_SUB, 32'd0, MOD_P - 1, 8'h23);
    for (int i = 0; i < 4; i++) begin
      run_op(OP_SUB, $urandom % MOD_P, $urandom % MOD_P, tag_t'(8'h30 + i));
    end
  endtask

  // The queue fills after four results and the remaining ones wait in the pipe
  task automatic queue_backpressure();
    dat_t rd;
    logic err;
    int polls;
    for (int i = 0; i < 6; i++) begin
      issue_cmd(mod_op_e'(i % 2), $urandom % MOD_P, $urandom % MOD_P, tag_t'(8'hA0 + i));
    end
    polls = 0;
    rd = '0;
    while (rd[7:4] != 4'(FIFO_DEPTH) && polls < POLL_LIMIT) begin
      apb_read(ADDR_STATUS, rd, err);
      polls++;
    end
    check_dat("status with full queue", rd, {24'h0, 4'(FIFO_DEPTH), 4'h1});
    for (int i = 0; i < 6; i++) begin
      collect_result();
    end
  endtask

  task automatic error_responses();
    dat_t rd;
    logic err;
    apb_read(ADDR_RESULT, rd, err);
    check_err("pslverr on empty pop", err, 1'b1);
    check_dat("prdata on empty pop", rd, '0);
    apb_read(8'h20, rd, err);
    check_err("pslverr on bad address", err, 1'b1);
    check_dat("prdata on bad address", rd, '0);
    run_op(OP_SUB, 32'd10, 32'd20, 8'h5A);
  endtask

  initial begin
    i_clk     = 1'b0;
    i_rst     = 1'b1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    dat_errs  = 0;
    tag_errs  = 0;
    bit_errs  = 0;
    misc_errs = 0;
    void'($urandom(RAND_SEED));
    repeat (5) @(posedge i_clk);
    i_rst <= 1'b0;
    reset_and_regs();
    add_cases();
    sub_cases();
    queue_backpressure();
    error_responses();
    $display("Errors: data %0d, tag %0d, error bit %0d, other %0d",
             dat_errs, tag_errs, bit_errs, misc_errs);
    if (dat_errs + tag_errs + bit_errs + misc_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Run did not finish within %0d ns", TIMEOUT_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== mod_arith_top.f ====
source/mod_arith_pkg.sv
source/mod_arith_ifs.sv
source/apb_cmd_regs.sv
source/mod_addsub_pipe.sv
source/result_fifo.sv
source/mod_arith_top.sv
tb/tb_mod_arith_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the engine and its testbench with Verilator and runs the simulation.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_mod_arith_top \
  -f mod_arith_top.f -o sim_mod_arith
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mod_arith > "$LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation run returned an error, see $LOG"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  echo "Test failed, see $LOG"
  exit 1
fi
echo "Test passed"
exit 0
